// ==== rtl/mipsPkg.sv ====
package mipsPkg;
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int regCount = 32;
	localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

	// Primary opcodes
	localparam logic [5:0] opRType = 6'd0;
	localparam logic [5:0] opJ = 6'd2;
	localparam logic [5:0] opJal = 6'd3;
	localparam logic [5:0] opBeq = 6'd4;
	localparam logic [5:0] opBne = 6'd5;
	localparam logic [5:0] opAddi = 6'd8;
	localparam logic [5:0] opAddiu = 6'd9;
	localparam logic [5:0] opSlti = 6'd10;
	localparam logic [5:0] opSltiu = 6'd11;
	localparam logic [5:0] opAndi = 6'd12;
	localparam logic [5:0] opOri = 6'd13;
	localparam logic [5:0] opXori = 6'd14;
	localparam logic [5:0] opLui = 6'd15;
	localparam logic [5:0] opLw = 6'd35;
	localparam logic [5:0] opSw = 6'd43;

	// SPECIAL function field
	localparam logic [5:0] fnSll = 6'd0;
	localparam logic [5:0] fnSrl = 6'd2;
	localparam logic [5:0] fnSra = 6'd3;
	localparam logic [5:0] fnJr = 6'd8;
	localparam logic [5:0] fnAdd = 6'd32;
	localparam logic [5:0] fnAddu = 6'd33;
	localparam logic [5:0] fnSub = 6'd34;
	localparam logic [5:0] fnSubu = 6'd35;
	localparam logic [5:0] fnAnd = 6'd36;
	localparam logic [5:0] fnOr = 6'd37;
	localparam logic [5:0] fnXor = 6'd38;
	localparam logic [5:0] fnNor = 6'd39;
	localparam logic [5:0] fnSlt = 6'd42;
	localparam logic [5:0] fnSltu = 6'd43;

	localparam int aluOpWidth = 4;
	localparam logic [aluOpWidth-1:0] aluAnd = 4'd0;
	localparam logic [aluOpWidth-1:0] aluOr = 4'd1;
	localparam logic [aluOpWidth-1:0] aluAdd = 4'd2;
	localparam logic [aluOpWidth-1:0] aluNor = 4'd3;
	localparam logic [aluOpWidth-1:0] aluXor = 4'd4;
	localparam logic [aluOpWidth-1:0] aluSub = 4'd6;
	localparam logic [aluOpWidth-1:0] aluSlt = 4'd7;
	localparam logic [aluOpWidth-1:0] aluLui = 4'd8;
	localparam logic [aluOpWidth-1:0] aluSll = 4'd10;
	localparam logic [aluOpWidth-1:0] aluSrl = 4'd13;
	localparam logic [aluOpWidth-1:0] aluSltu = 4'd14;
	localparam logic [aluOpWidth-1:0] aluSra = 4'd15;

	localparam logic [1:0] srcBReg = 2'd0;
	localparam logic [1:0] srcBImm = 2'd1;
	localparam logic [1:0] srcBShamt = 2'd2;

	localparam logic [1:0] wbAlu = 2'd0;
	localparam logic [1:0] wbMem = 2'd1;
	localparam logic [1:0] wbLink = 2'd2;

	localparam logic [1:0] fwdNone = 2'd0;
	localparam logic [1:0] fwdMem = 2'd1;
	localparam logic [1:0] fwdWb = 2'd2;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm16;
	} iFields_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [25:0] target26;
	} jFields_t;

	// One instruction word, three field layouts
	typedef union packed {
		rFields_t r;
		iFields_t i;
		jFields_t j;
	} instrWord_t;
endpackage

// ==== rtl/fetchStage.sv ====
`timescale 1ns/1ps
module fetchStage import mipsPkg::*; (
	input  logic Clk,
	input  logic arstN,
	input  logic stall,
	input  logic freeze,
	input  logic flushId,
	input  logic redirect,
	input  logic [dataWidth-1:0] redirectPc,
	output logic [dataWidth-1:0] instrAddr,
	input  logic [dataWidth-1:0] instrData,
	output instrWord_t idInstr,
	output logic [dataWidth-1:0] idPc
);
	logic [dataWidth-1:0] pc;

	assign instrAddr = pc;

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
			idInstr <= '0;
		end else if (!freeze) begin
			if (!stall)
				pc <= redirect ? redirectPc : pc + 32'd4;
			if (flushId)
				idInstr <= '0; // Bubble, decodes as sll r0
			else if (!stall)
				idInstr <= instrData;
		end
	end

	always_ff @(posedge Clk) begin
		if (!freeze && !stall)
			idPc <= pc;
	end
endmodule

// ==== rtl/decodeUnit.sv ====
`timescale 1ns/1ps
module decodeUnit import mipsPkg::*; (
	input  instrWord_t idInstr,
	input  logic [dataWidth-1:0] idPc,
	output logic [aluOpWidth-1:0] aluOp,
	output logic [1:0] srcB,
	output logic [dataWidth-1:0] imm,
	output logic [regAddrWidth-1:0] dest,
	output logic regWrite,
	output logic memRead,
	output logic memWrite,
	output logic [1:0] wbSel,
	output logic isBranchEq,
	output logic isBranchNe,
	output logic isJr,
	output logic jump,
	output logic [dataWidth-1:0] jumpTarget
);
	logic zeroExt;

	always_comb begin
		aluOp = aluAdd;
		srcB = srcBImm;
		zeroExt = 1'b0;
		dest = idInstr.i.rt;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		wbSel = wbAlu;
		isBranchEq = 1'b0;
		isBranchNe = 1'b0;
		isJr = 1'b0;
		jump = 1'b0;
		case (idInstr.r.opcode)
			opRType: begin
				dest = idInstr.r.rd;
				srcB = srcBReg;
				regWrite = 1'b1;
				case (idInstr.r.funct)
					fnAdd, fnAddu: aluOp = aluAdd;
					fnSub, fnSubu: aluOp = aluSub;
					fnAnd: aluOp = aluAnd;
					fnOr: aluOp = aluOr;
					fnXor: aluOp = aluXor;
					fnNor: aluOp = aluNor;
					fnSlt: aluOp = aluSlt;
					fnSltu: aluOp = aluSltu;
					fnSll, fnSrl, fnSra: begin
						srcB = srcBShamt;
						aluOp = (idInstr.r.funct == fnSll) ? aluSll :
							(idInstr.r.funct == fnSrl) ? aluSrl : aluSra;
					end
					fnJr: begin
						regWrite = 1'b0;
						isJr = 1'b1;
					end
					default: regWrite = 1'b0; // Unsupported funct runs as a NOP
				endcase
			end
			opAddi, opAddiu: regWrite = 1'b1;
			opSlti: begin
				aluOp = aluSlt;
				regWrite = 1'b1;
			end
			opSltiu: begin
				aluOp = aluSltu;
				regWrite = 1'b1;
			end
			opAndi, opOri, opXori, opLui: begin
				zeroExt = 1'b1;
				regWrite = 1'b1;
				aluOp = (idInstr.i.opcode == opAndi) ? aluAnd :
					(idInstr.i.opcode == opOri) ? aluOr :
					(idInstr.i.opcode == opXori) ? aluXor : aluLui;
			end
			opLw: begin
				regWrite = 1'b1;
				memRead = 1'b1;
				wbSel = wbMem;
			end
			opSw: memWrite = 1'b1;
			opBeq: isBranchEq = 1'b1;
			opBne: isBranchNe = 1'b1;
			opJ: jump = 1'b1;
			opJal: begin
				jump = 1'b1;
				regWrite = 1'b1;
				dest = linkReg;
				wbSel = wbLink;
			end
			default: ;
		endcase
	end

	assign imm = zeroExt ? {16'b0, idInstr.i.imm16} : {{16{idInstr.i.imm16[15]}}, idInstr.i.imm16};
	assign jumpTarget = {idPc[31:28], idInstr.j.target26, 2'b00};
endmodule

// ==== rtl/registerFile.sv ====
`timescale 1ns/1ps
module registerFile import mipsPkg::*; (
	input  logic Clk,
	input  logic arstN,
	input  logic [regAddrWidth-1:0] rsAddr,
	input  logic [regAddrWidth-1:0] rtAddr,
	output logic [dataWidth-1:0] rsData,
	output logic [dataWidth-1:0] rtData,
	input  logic wbWe,
	input  logic [regAddrWidth-1:0] wbDest,
	input  logic [dataWidth-1:0] wbData
);
	logic [dataWidth-1:0] regs [regCount];

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			for (int k = 0; k < regCount; k++)
				regs[k] <= '0;
		end else if (wbWe && wbDest != '0) begin
			regs[wbDest] <= wbData;
		end
	end

	// Write-through so decode sees the value being written back
	assign rsData = (rsAddr == '0) ? '0 : (wbWe && wbDest == rsAddr) ? wbData : regs[rsAddr];
	assign rtData = (rtAddr == '0) ? '0 : (wbWe && wbDest == rtAddr) ? wbData : regs[rtAddr];
endmodule

// ==== rtl/hazardUnit.sv ====
`timescale 1ns/1ps
module hazardUnit import mipsPkg::*; (
	input  logic [regAddrWidth-1:0] idRs,
	input  logic [regAddrWidth-1:0] idRt,
	input  logic [regAddrWidth-1:0] exRs,
	input  logic [regAddrWidth-1:0] exRt,
	input  logic exMemRead,
	input  logic [regAddrWidth-1:0] exDest,
	input  logic [regAddrWidth-1:0] memDest,
	input  logic memRegWrite,
	input  logic [regAddrWidth-1:0] wbDest,
	input  logic wbWe,
	input  logic branchTaken,
	input  logic jump,
	output logic [1:0] fwdA,
	output logic [1:0] fwdB,
	output logic stall,
	output logic flushId,
	output logic flushEx
);
	logic loadUse;

	// Youngest producer wins
	function automatic logic [1:0] fwdSel(input logic [regAddrWidth-1:0] src);
		if (src == '0)
			return fwdNone;
		if (memRegWrite && memDest == src)
			return fwdMem;
		if (wbWe && wbDest == src)
			return fwdWb;
		return fwdNone;
	endfunction

	assign fwdA = fwdSel(exRs);
	assign fwdB = fwdSel(exRt);

	assign loadUse = exMemRead && exDest != '0 && (exDest == idRs || exDest == idRt);
	assign stall = loadUse && !branchTaken;
	assign flushId = branchTaken || (jump && !loadUse); // Held jump redirects next cycle
	assign flushEx = branchTaken;
endmodule

// ==== rtl/executeStage.sv ====
`timescale 1ns/1ps
module executeStage import mipsPkg::*; (
	input  logic Clk,
	input  logic arstN,
	input  logic freeze,
	input  logic stall,
	input  logic flushEx,
	input  logic [aluOpWidth-1:0] aluOp,
	input  logic [1:0] srcB,
	input  logic [dataWidth-1:0] imm,
	input  logic [regAddrWidth-1:0] dest,
	input  logic regWrite,
	input  logic idMemRead,
	input  logic idMemWrite,
	input  logic [1:0] wbSel,
	input  logic isBranchEq,
	input  logic isBranchNe,
	input  logic isJr,
	input  logic [dataWidth-1:0] rsData,
	input  logic [dataWidth-1:0] rtData,
	input  instrWord_t idInstr,
	input  logic [dataWidth-1:0] idPc,
	input  logic [1:0] fwdA,
	input  logic [1:0] fwdB,
	input  logic [dataWidth-1:0] memFwdData,
	input  logic [dataWidth-1:0] wbData,
	output logic branchTaken,
	output logic [dataWidth-1:0] branchTarget,
	output logic [dataWidth-1:0] memAddr,
	output logic [dataWidth-1:0] memStoreData,
	output logic memRead,
	output logic memWrite,
	output logic memRegWrite,
	output logic [1:0] memWbSel,
	output logic [dataWidth-1:0] memLink,
	output logic [regAddrWidth-1:0] memDest,
	output logic [regAddrWidth-1:0] exRs,
	output logic [regAddrWidth-1:0] exRt,
	output logic [regAddrWidth-1:0] exDest,
	output logic exMemRead
);
	logic [aluOpWidth-1:0] exAluOp;
	logic [1:0] exSrcB, exWbSel;
	logic exRegWrite, exMemWrite, exBranchEq, exBranchNe, exJr;
	logic [dataWidth-1:0] exImm, exRsData, exRtData, exPc;
	instrWord_t exInstr;
	logic [dataWidth-1:0] opA, rtVal, aluA, aluB, aluRes;
	logic isShift;

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			{exRegWrite, exMemRead, exMemWrite, exBranchEq, exBranchNe, exJr} <= '0;
			exDest <= '0;
		end else if (!freeze) begin
			if (flushEx || stall) begin
				{exRegWrite, exMemRead, exMemWrite, exBranchEq, exBranchNe, exJr} <= '0;
				exDest <= '0;
			end else begin
				{exRegWrite, exMemRead, exMemWrite} <= {regWrite, idMemRead, idMemWrite};
				{exBranchEq, exBranchNe, exJr} <= {isBranchEq, isBranchNe, isJr};
				exDest <= dest;
			end
		end
	end

	always_ff @(posedge Clk) begin
		if (!freeze) begin
			exAluOp <= aluOp;
			exSrcB <= srcB;
			exWbSel <= wbSel;
			exImm <= imm;
			exRsData <= rsData;
			exRtData <= rtData;
			exInstr <= idInstr;
			exPc <= idPc;
		end
	end

	assign exRs = exInstr.r.rs;
	assign exRt = exInstr.r.rt;

	always_comb begin
		case (fwdA)
			fwdMem: opA = memFwdData;
			fwdWb: opA = wbData;
			default: opA = exRsData;
		endcase
		case (fwdB)
			fwdMem: rtVal = memFwdData;
			fwdWb: rtVal = wbData;
			default: rtVal = exRtData;
		endcase
	end

	// Shifts take rt as the shifted value
	assign isShift = exAluOp inside {aluSll, aluSrl, aluSra};
	assign aluA = isShift ? rtVal : opA;

	always_comb begin
		case (exSrcB)
			srcBImm: aluB = exImm;
			srcBShamt: aluB = {{(dataWidth-5){1'b0}}, exInstr.r.shamt};
			default: aluB = rtVal;
		endcase
		case (exAluOp)
			aluAnd: aluRes = aluA & aluB;
			aluOr: aluRes = aluA | aluB;
			aluXor: aluRes = aluA ^ aluB;
			aluNor: aluRes = ~(aluA | aluB);
			aluSub: aluRes = aluA - aluB;
			aluSlt: aluRes = {{(dataWidth-1){1'b0}}, $signed(aluA) < $signed(aluB)};
			aluSltu: aluRes = {{(dataWidth-1){1'b0}}, aluA < aluB};
			aluSll: aluRes = aluA << aluB[4:0];
			aluSrl: aluRes = aluA >> aluB[4:0];
			aluSra: aluRes = $signed(aluA) >>> aluB[4:0];
			aluLui: aluRes = {aluB[15:0], 16'b0};
			default: aluRes = aluA + aluB;
		endcase
	end

	assign branchTaken = (exBranchEq && opA == rtVal) || (exBranchNe && opA != rtVal) || exJr;
	assign branchTarget = exJr ? opA : exPc + 32'd4 + {exImm[dataWidth-3:0], 2'b00};

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			{memRead, memWrite, memRegWrite} <= '0;
			memDest <= '0;
		end else if (!freeze) begin
			{memRead, memWrite, memRegWrite} <= {exMemRead, exMemWrite, exRegWrite};
			memDest <= exDest;
		end
	end

	always_ff @(posedge Clk) begin
		if (!freeze) begin
			memAddr <= aluRes;
			memStoreData <= rtVal;
			memWbSel <= exWbSel;
			memLink <= exPc + 32'd4; // Return address for JAL
		end
	end
endmodule

// ==== rtl/memoryStage.sv ====
`timescale 1ns/1ps
module memoryStage import mipsPkg::*; (
	input  logic Clk,
	input  logic arstN,
	input  logic [dataWidth-1:0] memAddr,
	input  logic [dataWidth-1:0] memStoreData,
	input  logic memRead,
	input  logic memWrite,
	input  logic memRegWrite,
	input  logic [1:0] memWbSel,
	input  logic [dataWidth-1:0] memLink,
	input  logic [regAddrWidth-1:0] memDest,
	output logic dataCyc,
	output logic dataStb,
	output logic dataWe,
	output logic [dataWidth-1:0] dataAdr,
	output logic [dataWidth-1:0] dataDatW,
	input  logic [dataWidth-1:0] dataDatR,
	input  logic dataAck,
	output logic freeze,
	output logic [dataWidth-1:0] memFwdData,
	output logic wbWe,
	output logic [regAddrWidth-1:0] wbDest,
	output logic [dataWidth-1:0] wbData
);
	logic access;

	// EX/MEM holds still while frozen, so the bus stays stable until ack
	assign access = memRead | memWrite;
	assign dataCyc = access;
	assign dataStb = access;
	assign dataWe = memWrite;
	assign dataAdr = memAddr;
	assign dataDatW = memStoreData;
	assign freeze = access & ~dataAck;

	// Also feeds EX forwarding; load data is valid in the ack cycle
	always_comb begin
		case (memWbSel)
			wbMem: memFwdData = dataDatR;
			wbLink: memFwdData = memLink;
			default: memFwdData = memAddr;
		endcase
	end

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			wbWe <= 1'b0;
			wbDest <= '0;
		end else if (!freeze) begin
			wbWe <= memRegWrite;
			wbDest <= memDest;
		end
	end

	always_ff @(posedge Clk) begin
		if (!freeze)
			wbData <= memFwdData;
	end
endmodule

// ==== rtl/mipsCore.sv ====
`timescale 1ns/1ps
module mipsCore import mipsPkg::*; (
	input  logic Clk,
	input  logic arstN,
	output logic [dataWidth-1:0] instrAddr,
	input  logic [dataWidth-1:0] instrData,
	output logic dataCyc,
	output logic dataStb,
	output logic dataWe,
	output logic [dataWidth-1:0] dataAdr,
	output logic [dataWidth-1:0] dataDatW,
	input  logic [dataWidth-1:0] dataDatR,
	input  logic dataAck
);
	instrWord_t idInstr;
	logic [dataWidth-1:0] idPc;
	logic [aluOpWidth-1:0] aluOp;
	logic [1:0] srcB, wbSel, memWbSel;
	logic [dataWidth-1:0] imm, jumpTarget;
	logic [regAddrWidth-1:0] dest, exRs, exRt, exDest, memDest, wbDest;
	logic regWrite, idMemRead, idMemWrite;
	logic isBranchEq, isBranchNe, isJr, jump;
	logic [dataWidth-1:0] rsData, rtData;
	logic [1:0] fwdA, fwdB;
	logic stall, flushId, flushEx, memBusy;
	logic branchTaken, exMemRead;
	logic [dataWidth-1:0] branchTarget, memAddr, memStoreData, memLink, memFwdData, wbData;
	logic memRead, memWrite, memRegWrite, wbWe;
	logic redirect;
	logic [dataWidth-1:0] redirectPc;

	// Branch in EX is older than a jump in ID
	assign redirect = branchTaken | jump;
	assign redirectPc = branchTaken ? branchTarget : jumpTarget;

	fetchStage fetchStage_inst (.Clk(Clk), .arstN(arstN), .stall(stall), .freeze(memBusy),
		.flushId(flushId), .redirect(redirect), .redirectPc(redirectPc),
		.instrAddr(instrAddr), .instrData(instrData), .idInstr(idInstr), .idPc(idPc));

	decodeUnit decodeUnit_inst (.idInstr(idInstr), .idPc(idPc), .aluOp(aluOp), .srcB(srcB),
		.imm(imm), .dest(dest), .regWrite(regWrite), .memRead(idMemRead),
		.memWrite(idMemWrite), .wbSel(wbSel), .isBranchEq(isBranchEq),
		.isBranchNe(isBranchNe), .isJr(isJr), .jump(jump), .jumpTarget(jumpTarget));

	registerFile registerFile_inst (.Clk(Clk), .arstN(arstN), .rsAddr(idInstr.r.rs),
		.rtAddr(idInstr.r.rt), .rsData(rsData), .rtData(rtData), .wbWe(wbWe),
		.wbDest(wbDest), .wbData(wbData));

	hazardUnit hazardUnit_inst (.idRs(idInstr.r.rs), .idRt(idInstr.r.rt), .exRs(exRs),
		.exRt(exRt), .exMemRead(exMemRead), .exDest(exDest), .memDest(memDest),
		.memRegWrite(memRegWrite), .wbDest(wbDest), .wbWe(wbWe), .branchTaken(branchTaken),
		.jump(jump), .fwdA(fwdA), .fwdB(fwdB), .stall(stall), .flushId(flushId),
		.flushEx(flushEx));

	executeStage executeStage_inst (.Clk(Clk), .arstN(arstN), .freeze(memBusy),
		.stall(stall), .flushEx(flushEx), .aluOp(aluOp), .srcB(srcB), .imm(imm),
		.dest(dest), .regWrite(regWrite), .idMemRead(idMemRead), .idMemWrite(idMemWrite),
		.wbSel(wbSel), .isBranchEq(isBranchEq), .isBranchNe(isBranchNe), .isJr(isJr),
		.rsData(rsData), .rtData(rtData), .idInstr(idInstr), .idPc(idPc), .fwdA(fwdA),
		.fwdB(fwdB), .memFwdData(memFwdData), .wbData(wbData), .branchTaken(branchTaken),
		.branchTarget(branchTarget), .memAddr(memAddr), .memStoreData(memStoreData),
		.memRead(memRead), .memWrite(memWrite), .memRegWrite(memRegWrite),
		.memWbSel(memWbSel), .memLink(memLink), .memDest(memDest), .exRs(exRs),
		.exRt(exRt), .exDest(exDest), .exMemRead(exMemRead));

	memoryStage memoryStage_inst (.Clk(Clk), .arstN(arstN), .memAddr(memAddr),
		.memStoreData(memStoreData), .memRead(memRead), .memWrite(memWrite),
		.memRegWrite(memRegWrite), .memWbSel(memWbSel), .memLink(memLink),
		.memDest(memDest), .dataCyc(dataCyc), .dataStb(dataStb), .dataWe(dataWe),
		.dataAdr(dataAdr), .dataDatW(dataDatW), .dataDatR(dataDatR), .dataAck(dataAck),
		.freeze(memBusy), .memFwdData(memFwdData), .wbWe(wbWe), .wbDest(wbDest),
		.wbData(wbData));
endmodule

// ==== include/tbTests.svh ====
`ifndef TBTESTS_SVH
`define TBTESTS_SVH

// Back to back producers hit MEM and WB forwarding
task automatic aluChainTest();
	beginProgram();
	iInstr(opAddiu, 5'd0, 5'd1, 16'h1234);
	regModel[1] = 32'h0000_1234;
	iInstr(opLui, 5'd0, 5'd2, 16'h8000);
	regModel[2] = 32'h8000_0000;
	rInstr(5'd1, 5'd2, 5'd3, 5'd0, fnAddu);
	regModel[3] = regModel[1] + regModel[2];
	storeReg(5'd3);
	rInstr(5'd3, 5'd1, 5'd4, 5'd0, fnSubu);
	regModel[4] = regModel[3] - regModel[1];
	rInstr(5'd0, 5'd4, 5'd5, 5'd4, fnSra);
	regModel[5] = $signed(regModel[4]) >>> 4;
	storeReg(5'd5);
	rInstr(5'd0, 5'd4, 5'd6, 5'd4, fnSrl);
	regModel[6] = regModel[4] >> 4;
	rInstr(5'd5, 5'd6, 5'd7, 5'd0, fnXor);
	regModel[7] = regModel[5] ^ regModel[6];
	storeReg(5'd7);
	rInstr(5'd0, 5'd1, 5'd8, 5'd8, fnSll);
	regModel[8] = regModel[1] << 8;
	storeReg(5'd8);
	rInstr(5'd4, 5'd1, 5'd9, 5'd0, fnSlt); // Negative below positive
	regModel[9] = {31'b0, $signed(regModel[4]) < $signed(regModel[1])};
	storeReg(5'd9);
	rInstr(5'd4, 5'd1, 5'd10, 5'd0, fnSltu);
	regModel[10] = {31'b0, regModel[4] < regModel[1]};
	storeReg(5'd10);
	rInstr(5'd9, 5'd10, 5'd11, 5'd0, fnNor);
	regModel[11] = ~(regModel[9] | regModel[10]);
	storeReg(5'd11);
	iInstr(opOri, 5'd11, 5'd12, 16'h0001);
	regModel[12] = regModel[11] | 32'h0000_0001;
	iInstr(opSlti, 5'd12, 5'd13, 16'h0000);
	regModel[13] = {31'b0, $signed(regModel[12]) < 0};
	storeReg(5'd13);
	iInstr(opSltiu, 5'd8, 5'd14, 16'hffff); // Immediate is sign extended, then unsigned
	regModel[14] = {31'b0, regModel[8] < 32'hffff_ffff};
	storeReg(5'd14);
	iInstr(opAddi, 5'd13, 5'd15, 16'hfffd);
	regModel[15] = regModel[13] + 32'hffff_fffd;
	storeReg(5'd15);
	iInstr(opAndi, 5'd12, 5'd16, 16'h8f0f);
	regModel[16] = regModel[12] & 32'h0000_8f0f;
	rInstr(5'd15, 5'd16, 5'd17, 5'd0, fnAdd);
	regModel[17] = regModel[15] + regModel[16];
	storeReg(5'd17);
	iInstr(opXori, 5'd17, 5'd18, 16'hf0f0);
	regModel[18] = regModel[17] ^ 32'h0000_f0f0;
	rInstr(5'd1, 5'd18, 5'd19, 5'd0, fnSub);
	regModel[19] = regModel[1] - regModel[18];
	rInstr(5'd19, 5'd11, 5'd20, 5'd0, fnAnd);
	regModel[20] = regModel[19] & regModel[11];
	storeReg(5'd20);
	rInstr(5'd19, 5'd8, 5'd21, 5'd0, fnOr);
	regModel[21] = regModel[19] | regModel[8];
	storeReg(5'd21);
	runProgram();
endtask

task automatic loadUseTest();
	beginProgram();
	iInstr(opAddiu, 5'd0, 5'd1, 16'd7);
	regModel[1] = 32'd7;
	iInstr(opLw, 5'd1, 5'd2, 16'h01f9); // Base from the previous result
	regModel[2] = fillWord(regModel[1] + 32'h0000_01f9);
	rInstr(5'd2, 5'd1, 5'd3, 5'd0, fnAdd);
	regModel[3] = regModel[2] + regModel[1];
	storeReg(5'd3);
	iInstr(opLw, 5'd0, 5'd4, 16'h0204);
	regModel[4] = fillWord(32'h0000_0204);
	storeReg(5'd4);
	iInstr(opLw, 5'd0, 5'd5, 16'h0100); // Reads back the first store
	regModel[5] = regModel[3];
	rInstr(5'd5, 5'd5, 5'd6, 5'd0, fnAddu);
	regModel[6] = regModel[5] + regModel[5];
	storeReg(5'd6);
	runProgram();
endtask

task automatic branchTest();
	beginProgram();
	iInstr(opAddiu, 5'd0, 5'd1, 16'd5);
	regModel[1] = 32'd5;
	iInstr(opAddiu, 5'd0, 5'd2, 16'd5);
	regModel[2] = 32'd5;
	iInstr(opBeq, 5'd1, 5'd2, 16'd2);
	storeTo(5'd1, badAddr);
	storeTo(5'd2, badAddr);
	iInstr(opAddiu, 5'd0, 5'd3, 16'h0033);
	regModel[3] = 32'h0000_0033;
	storeReg(5'd3);
	iInstr(opBne, 5'd1, 5'd2, 16'd2); // Falls through
	iInstr(opAddiu, 5'd0, 5'd4, 16'h0044);
	regModel[4] = 32'h0000_0044;
	storeReg(5'd4);
	iInstr(opBne, 5'd1, 5'd3, 16'd2);
	storeTo(5'd1, badAddr);
	storeTo(5'd1, badAddr);
	iInstr(opBeq, 5'd1, 5'd3, 16'd1); // Falls through
	iInstr(opAddiu, 5'd0, 5'd5, 16'h0055);
	regModel[5] = 32'h0000_0055;
	storeReg(5'd5);
	runProgram();
endtask

// Word 1 holds JAL, the routine sits at word 6
task automatic jumpTest();
	beginProgram();
	iInstr(opAddiu, 5'd0, 5'd1, 16'h0011);
	jInstr(opJal, 26'd6);
	storeTo(5'd31, 32'h0000_0104);
	jInstr(opJ, 26'd9);
	storeTo(5'd1, badAddr);
	storeTo(5'd1, badAddr);
	iInstr(opAddiu, 5'd0, 5'd2, 16'h0022);
	storeTo(5'd2, 32'h0000_0100);
	rInstr(5'd31, 5'd0, 5'd0, 5'd0, fnJr);
	iInstr(opAddiu, 5'd0, 5'd3, 16'h0033); // J target reached only after the return
	storeTo(5'd3, 32'h0000_0108);
	expectStore(32'h0000_0100, 32'h0000_0022);
	expectStore(32'h0000_0104, 32'd1 * 4 + 32'd4);
	expectStore(32'h0000_0108, 32'h0000_0033);
	runProgram();
endtask

`endif

// ==== verif/tbMipsCore.sv ====
`timescale 1ns/1ps
module tbMipsCore import mipsPkg::*; ();
	localparam int romWords = 64;
	localparam int dmemWords = 256;
	localparam logic [dataWidth-1:0] doneAddr = 32'h0000_03fc;
	localparam logic [dataWidth-1:0] badAddr = 32'h0000_0300;

	logic Clk;
	logic arstN;
	logic [dataWidth-1:0] instrAddr;
	logic [dataWidth-1:0] instrData;
	logic dataCyc;
	logic dataStb;
	logic dataWe;
	logic [dataWidth-1:0] dataAdr;
	logic [dataWidth-1:0] dataDatW;
	logic [dataWidth-1:0] dataDatR;
	logic dataAck;

	instrWord_t rom [romWords];
	logic [dataWidth-1:0] dmem [dmemWords];
	logic [dataWidth-1:0] regModel [regCount];
	logic [dataWidth-1:0] storeAddrQ [$];
	logic [dataWidth-1:0] storeDataQ [$];
	logic [dataWidth-1:0] expAddrQ [$];
	logic [dataWidth-1:0] expDataQ [$];
	logic [dataWidth-1:0] lcgState;
	logic [dataWidth-1:0] slotAddr;
	logic [dataWidth-1:0] heldAdr;
	logic [dataWidth-1:0] heldDat;
	logic heldWe;
	logic inAccess;
	logic doneSeen;
	logic running;
	int progLen;
	int waitLeft;
	int cycleCount;
	int cycleLimit;

	mipsCore mipsCore_inst (.Clk(Clk), .arstN(arstN), .instrAddr(instrAddr),
		.instrData(instrData), .dataCyc(dataCyc), .dataStb(dataStb), .dataWe(dataWe),
		.dataAdr(dataAdr), .dataDatW(dataDatW), .dataDatR(dataDatR), .dataAck(dataAck));

	initial begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;
	end

	// Past the program the ROM reads as NOP
	assign instrData = (instrAddr < romWords * 4) ? rom[instrAddr[7:2]] : '0;

	function automatic logic [dataWidth-1:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic [dataWidth-1:0] fillWord(input logic [dataWidth-1:0] addr);
		return 32'hc3a5_0000 ^ {addr[15:0], addr[31:16]} ^ addr;
	endfunction

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input logic [dataWidth-1:0] got,
			input logic [dataWidth-1:0] exp);
		if (got !== exp)
			reportFailure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic checkAddr(input string name, input logic [dataWidth-1:0] got,
			input logic [dataWidth-1:0] exp);
		if (got !== exp)
			reportFailure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// Wishbone slave, 0 to 3 wait states per access
	initial begin
		logic [dataWidth-1:0] rnd;
		dataAck = 1'b0;
		dataDatR = '0;
		waitLeft = -1;
		lcgState = 32'h465cf933;
		forever begin
			@(posedge Clk);
			#1;
			if (!arstN || dataAck) begin // Handshake ended at this edge
				dataAck = 1'b0;
				waitLeft = -1;
			end
			if (arstN && dataStb) begin
				if (waitLeft < 0) begin
					rnd = nextRand();
					waitLeft = int'(rnd[31:30]);
				end
				if (waitLeft == 0) begin
					dataAck = 1'b1;
					dataDatR = dmem[dataAdr[9:2]];
				end else begin
					waitLeft = waitLeft - 1;
				end
			end
		end
	end

	// Bus monitor, sampled mid-cycle
	always @(negedge Clk) begin
		if (!arstN) begin
			inAccess = 1'b0;
		end else begin
			if (dataStb !== dataCyc)
				reportFailure("dataStb and dataCyc differ outside reset");
			if (dataStb) begin
				if (inAccess) begin
					checkAddr("dataAdr", dataAdr, heldAdr);
					if (dataWe !== heldWe)
						reportFailure("dataWe changed before the acknowledge");
					if (heldWe)
						checkWord("dataDatW", dataDatW, heldDat);
				end else begin
					inAccess = 1'b1;
					heldAdr = dataAdr;
					heldWe = dataWe;
					heldDat = dataDatW;
				end
				if (dataAck) begin
					inAccess = 1'b0;
					if (dataWe) begin
						dmem[dataAdr[9:2]] = dataDatW;
						storeAddrQ.push_back(dataAdr);
						storeDataQ.push_back(dataDatW);
						if (dataAdr == doneAddr)
							doneSeen = 1'b1;
					end
				end
			end
		end
	end

	always @(posedge Clk) begin
		if (running) begin
			cycleCount = cycleCount + 1;
			if (cycleCount > cycleLimit)
				reportFailure($sformatf("timeout, no done store after %0d cycles", cycleCount));
		end
	end

	task automatic appendInstr(input instrWord_t w);
		rom[progLen] = w;
		progLen = progLen + 1;
	endtask

	task automatic rInstr(input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd,
			input logic [4:0] shamt, input logic [5:0] funct);
		instrWord_t w;
		w.r = rFields_t'{opRType, rs, rt, rd, shamt, funct};
		appendInstr(w);
	endtask

	task automatic iInstr(input logic [5:0] op, input logic [4:0] rs, input logic [4:0] rt,
			input logic [15:0] imm16);
		instrWord_t w;
		w.i = iFields_t'{op, rs, rt, imm16};
		appendInstr(w);
	endtask

	task automatic jInstr(input logic [5:0] op, input logic [25:0] target26);
		instrWord_t w;
		w.j = jFields_t'{op, target26};
		appendInstr(w);
	endtask

	task automatic storeTo(input logic [4:0] rt, input logic [dataWidth-1:0] addr);
		iInstr(opSw, 5'd0, rt, addr[15:0]);
	endtask

	task automatic expectStore(input logic [dataWidth-1:0] addr,
			input logic [dataWidth-1:0] data);
		expAddrQ.push_back(addr);
		expDataQ.push_back(data);
	endtask

	// Store to the next result slot
	task automatic storeReg(input logic [4:0] r);
		storeTo(r, slotAddr);
		expectStore(slotAddr, regModel[r]);
		slotAddr = slotAddr + 32'd4;
	endtask

	task automatic beginProgram();
		arstN = 1'b0;
		running = 1'b0;
		doneSeen = 1'b0;
		progLen = 0;
		slotAddr = 32'h0000_0100;
		storeAddrQ.delete();
		storeDataQ.delete();
		expAddrQ.delete();
		expDataQ.delete();
		for (int k = 0; k < romWords; k++)
			rom[k] = '0;
		for (int k = 0; k < dmemWords; k++)
			dmem[k] = fillWord(k * 4);
		for (int k = 0; k < regCount; k++)
			regModel[k] = '0;
	endtask

	task automatic checkStores();
		if (storeAddrQ.size() != expAddrQ.size())
			reportFailure($sformatf("the core made %0d stores where %0d were expected",
				storeAddrQ.size(), expAddrQ.size()));
		for (int k = 0; k < expAddrQ.size(); k++) begin
			checkAddr($sformatf("store %0d dataAdr", k), storeAddrQ[k], expAddrQ[k]);
			checkWord($sformatf("store %0d dataDatW", k), storeDataQ[k], expDataQ[k]);
		end
	endtask

	// Reset held since beginProgram, 3 cycles
	task automatic runProgram();
		storeTo(5'd0, doneAddr);
		expectStore(doneAddr, '0);
		cycleLimit = progLen * 40 * 4;
		repeat (3) begin
			@(posedge Clk);
			#1;
			if (dataCyc)
				reportFailure("dataCyc is high during reset");
		end
		arstN = 1'b1;
		cycleCount = 0;
		running = 1'b1;
		@(posedge Clk);
		#1;
		if (dataCyc)
			reportFailure("dataCyc is high in the first cycle after reset");
		while (!doneSeen)
			@(posedge Clk);
		#1;
		running = 1'b0;
		checkStores();
	endtask

	`include "tbTests.svh"

	initial begin
		arstN = 1'b0;
		running = 1'b0;
		cycleCount = 0;
		cycleLimit = 0;
		aluChainTest();
		loadUseTest();
		branchTest();
		jumpTest();
		$display("All tests passed!");
		$finish;
	end
endmodule

// ==== list.f ====
+incdir+include
rtl/mipsPkg.sv
rtl/fetchStage.sv
rtl/decodeUnit.sv
rtl/registerFile.sv
rtl/hazardUnit.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/mipsCore.sv
verif/tbMipsCore.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --top-module tbMipsCore -f list.f -o simv > build.log 2>&1 \
	&& ./obj_dir/simv > sim.log 2>&1 \
	|| echo "build or simulation ended with an error, see build.log and sim.log"
grep -q 'All tests passed!' sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
